/* all.f */
+incdir+src
src/rv_isa_pkg.sv
src/rv_ctrl_pkg.sv
src/alu.sv
src/regfile.sv
src/immediate_generator.sv
src/singlecycle_datapath.sv
src/singlecycle_control.sv
src/rvsimple_core.sv
verification/rvsimple_checker.sv
verification/rvsimple_tb.sv

/* run.sh */
#!/bin/sh
# Build with Verilator and run the testbench; exit status follows the result
verilator --binary --timing --assert -f all.f --top-module rvsimple_tb \
  && ./obj_dir/Vrvsimple_tb | tee /dev/stderr | grep -q "Testbench passed" \
  && echo "run.sh: simulation passed" \
  || { echo "run.sh: simulation failed"; exit 1; }

/* verification/rvsimple_tb.sv */
/*
 * Testbench for the single-cycle core. Builds a program, runs an ISA
 * model over it for the expected stores, then runs the DUT per section.
 */

`timescale 1ns/1ps

`include "rv_consts.svh"

module rvsimple_tb;

  localparam logic [6:0] LOAD = 7'b0000011;
  localparam logic [6:0] IMM = 7'b0010011;
  localparam logic [6:0] REG = 7'b0110011;
  localparam logic [31:0] HALT = 32'h0000_006f;

  logic clock = 1'b0;
  logic rst_n;
  logic [31:0] pc, inst, dm_addr, dm_wdata, dm_rdata;
  logic dm_we, dm_re;
  logic [31:0] imem [0:255];
  logic [31:0] dmem [0:255];
  logic [31:0] m_mem [0:255];
  logic [31:0] m_regs [0:31];
  logic [31:0] exp_addr [$];
  logic [31:0] exp_data [$];
  logic [31:0] exp_pc [$];
  logic [31:0] exp_load_pc [$];
  logic [31:0] end_label [0:3];
  logic [31:0] lcg_state = 32'h5576_6c4b;
  logic [31:0] prev_pc;
  logic [6:0] prev_op;
  logic prev_valid = 1'b0;
  logic timed_out = 1'b0;
  int ip = 0;
  int st_off = 32'h200;
  int store_count = 0;
  int load_count = 0;
  int errors = 0;
  int tests_passed = 0;
  int tests_failed = 0;

  always #10 clock = ~clock;

  rvsimple_core dut_i (
    .clock                 (clock),
    .rst_n                 (rst_n),
    .pc                    (pc),
    .inst                  (inst),
    .data_mem_address      (dm_addr),
    .data_mem_write_data   (dm_wdata),
    .data_mem_write_enable (dm_we),
    .data_mem_read_enable  (dm_re),
    .data_mem_read_data    (dm_rdata)
  );

  assign inst = imem[pc[9:2]];
  assign dm_rdata = dmem[dm_addr[9:2]];

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // ----------------------------------------------------------------------
  // Instruction encoders and program builder
  // ----------------------------------------------------------------------

  function automatic logic [31:0] i_enc(logic [31:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                        logic [4:0] rd, logic [6:0] op);
    return {imm[11:0], rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] s_enc(logic [31:0] imm, logic [4:0] rs2);
    return {imm[11:5], rs2, 5'd0, 3'b010, imm[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] b_enc(logic [31:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                        logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] j_enc(logic [31:0] imm, logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
  endfunction

  task automatic emit(input logic [31:0] w);
    imem[ip] = w;
    ip++;
  endtask

  task automatic store_reg(input logic [4:0] rs2);
    emit(s_enc(st_off, rs2));
    st_off += 4;
  endtask

  task automatic build_program();
    logic [2:0] f3s [0:9];
    logic [2:0] bf3 [0:5];
    logic [4:0] ra [0:2];
    logic [4:0] rb [0:2];
    logic alts [0:9];
    logic [31:0] imm;
    int p;
    f3s = '{3'd0, 3'd0, 3'd1, 3'd2, 3'd3, 3'd4, 3'd5, 3'd5, 3'd6, 3'd7};
    alts = '{1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0};
    bf3 = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
    ra = '{5'd10, 5'd11, 5'd10};
    rb = '{5'd11, 5'd10, 5'd10};
    // Arithmetic on loaded operands
    emit(i_enc(0, 5'd0, 3'b010, 5'd1, LOAD));
    emit(i_enc(4, 5'd0, 3'b010, 5'd2, LOAD));
    for (int k = 0; k < 10; k++) begin
      emit({alts[k] ? 7'h20 : 7'h00, 5'd2, 5'd1, f3s[k], 5'd3, REG});
      store_reg(5'd3);
      if (k != 1) begin
        imm = (f3s[k] == 3'd1 || f3s[k] == 3'd5) ? {20'd0, alts[k] ? 7'h20 : 7'h00, 5'd7}
                                                 : 32'hffff_ffdb;
        emit(i_enc(imm, 5'd1, f3s[k], 5'd3, IMM));
        store_reg(5'd3);
      end
    end
    end_label[0] = ip * 4;
    // Upper immediates and link values
    emit({20'habcde, 5'd5, 7'b0110111});
    store_reg(5'd5);
    emit({20'h12345, 5'd6, 7'b0010111});
    store_reg(5'd6);
    emit(j_enc(8, 5'd7));
    store_reg(5'd0);
    store_reg(5'd7);
    p = ip * 4;
    emit(i_enc((p + 12) | 1, 5'd0, 3'd0, 5'd8, IMM));
    emit(i_enc(0, 5'd8, 3'd0, 5'd9, 7'b1100111));
    store_reg(5'd0);
    store_reg(5'd9);
    end_label[1] = ip * 4;
    // Branch pairs where each path stores its own marker to one slot
    emit(i_enc(32'hffff_fffd, 5'd0, 3'd0, 5'd10, IMM));
    emit(i_enc(4, 5'd0, 3'd0, 5'd11, IMM));
    for (int b = 0; b < 6; b++) begin
      for (int q = 0; q < 3; q++) begin
        emit(b_enc(16, rb[q], ra[q], bf3[b]));
        emit(i_enc(1, 5'd0, 3'd0, 5'd12, IMM));
        emit(s_enc(st_off, 5'd12));
        emit(j_enc(12, 5'd0));
        emit(i_enc(2, 5'd0, 3'd0, 5'd12, IMM));
        emit(s_enc(st_off, 5'd12));
        st_off += 4;
      end
    end
    end_label[2] = ip * 4;
    emit(i_enc(55, 5'd0, 3'd0, 5'd0, IMM));
    store_reg(5'd0);
    end_label[3] = ip * 4;
    emit(HALT);
  endtask

  // ----------------------------------------------------------------------
  // ISA reference model
  // ----------------------------------------------------------------------

  function automatic logic [31:0] arith(logic [2:0] f3, logic alt, logic [31:0] a,
                                        logic [31:0] b);
    case (f3)
      3'd0: return alt ? a - b : a + b;
      3'd1: return a << b[4:0];
      3'd2: return {31'd0, $signed(a) < $signed(b)};
      3'd3: return {31'd0, a < b};
      3'd4: return a ^ b;
      3'd5: begin
        if (alt) begin
          return $signed(a) >>> b[4:0];
        end else begin
          return a >> b[4:0];
        end
      end
      3'd6: return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic taken(logic [2:0] f3, logic [31:0] a, logic [31:0] b);
    case (f3)
      3'd0: return a == b;
      3'd1: return a != b;
      3'd4: return $signed(a) < $signed(b);
      3'd5: return $signed(a) >= $signed(b);
      3'd6: return a < b;
      default: return a >= b;
    endcase
  endfunction

  task automatic run_model();
    logic [31:0] mpc, w, a, b, res, imm_i, imm_s, imm_b, imm_j;
    logic wr;
    mpc = `RV_INITIAL_PC;
    for (int s = 0; s < 4000 && imem[mpc[9:2]] != HALT; s++) begin
      w = imem[mpc[9:2]];
      a = (w[19:15] == 5'd0) ? 32'd0 : m_regs[w[19:15]];
      b = (w[24:20] == 5'd0) ? 32'd0 : m_regs[w[24:20]];
      imm_i = {{20{w[31]}}, w[31:20]};
      imm_s = {{20{w[31]}}, w[31:25], w[11:7]};
      imm_b = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
      imm_j = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
      wr = 1'b1;
      res = 32'd0;
      case (w[6:0])
        7'b0110111: res = {w[31:12], 12'd0};
        7'b0010111: res = mpc + {w[31:12], 12'd0};
        LOAD: res = m_mem[(a + imm_i) >> 2];
        IMM: res = arith(w[14:12], w[14:12] == 3'd5 && w[30], a, imm_i);
        REG: res = arith(w[14:12], w[30], a, b);
        7'b1101111, 7'b1100111: res = mpc + 32'd4;
        default: wr = 1'b0;
      endcase
      if (w[6:0] == LOAD) begin
        exp_load_pc.push_back(mpc);
      end
      if (w[6:0] == 7'b0100011) begin
        m_mem[(a + imm_s) >> 2] = b;
        exp_addr.push_back(a + imm_s);
        exp_data.push_back(b);
        exp_pc.push_back(mpc);
      end
      if (wr && w[11:7] != 5'd0) begin
        m_regs[w[11:7]] = res;
      end
      if (w[6:0] == 7'b1101111) begin
        mpc = mpc + imm_j;
      end else if (w[6:0] == 7'b1100111) begin
        mpc = (a + imm_i) & 32'hffff_fffe;
      end else if (w[6:0] == 7'b1100011 && taken(w[14:12], a, b)) begin
        mpc = mpc + imm_b;
      end else begin
        mpc = mpc + 32'd4;
      end
    end
  endtask

  // ----------------------------------------------------------------------
  // Data memory, strobe checks and pc monitor
  // ----------------------------------------------------------------------

  always @(posedge clock) begin
    if (dm_we) begin
      assert (store_count < exp_addr.size() && dm_addr == exp_addr[store_count]
              && dm_wdata == exp_data[store_count])
      else begin
        $display("error @%0t: store #%0d addr %h data %h", $time, store_count,
                 dm_addr, dm_wdata);
        errors++;
      end
      dmem[dm_addr[9:2]] = dm_wdata;
      store_count++;
    end
    if (dm_re) begin
      load_count++;
    end
    // Backward pc steps only after a branch or jump
    if (prev_valid && pc < prev_pc) begin
      assert (prev_op == 7'b1100011 || prev_op == 7'b1101111 || prev_op == 7'b1100111)
      else begin
        $display("error @%0t: pc stepped back to %h", $time, pc);
        errors++;
      end
    end
    prev_pc = pc;
    prev_op = inst[6:0];
    prev_valid = rst_n;
  end

  task automatic run_section(input string name, input logic [31:0] label);
    int cycles;
    int start_errors;
    int want;
    int want_loads;
    cycles = 0;
    start_errors = errors;
    want = 0;
    want_loads = 0;
    if (timed_out) begin
      $display("test %s: not run after an earlier timeout", name);
      tests_failed++;
    end else begin
      while (pc != label && cycles < 500) begin
        @(negedge clock);
        cycles++;
      end
      if (pc != label) begin
        $display("timeout waiting for pc %h in test %s", label, name);
        timed_out = 1'b1;
        tests_failed++;
      end else begin
        foreach (exp_pc[i]) begin
          if (exp_pc[i] < label) want++;
        end
        foreach (exp_load_pc[i]) begin
          if (exp_load_pc[i] < label) want_loads++;
        end
        assert (store_count == want)
        else begin
          $display("error @%0t: %0d stores seen, %0d expected", $time, store_count, want);
          errors++;
        end
        assert (load_count == want_loads)
        else begin
          $display("error @%0t: %0d loads seen, %0d expected", $time, load_count,
                   want_loads);
          errors++;
        end
        if (errors == start_errors) tests_passed++;
        else tests_failed++;
        $display("test %s: %s", name, (errors == start_errors) ? "ok" : "FAILED");
      end
    end
  endtask

  initial begin
    rst_n <= 1'b0;
    for (int i = 0; i < 256; i++) begin
      imem[i] = 32'd0;
      dmem[i] = lcg_next();
      m_mem[i] = dmem[i];
    end
    for (int i = 0; i < 32; i++) m_regs[i] = 32'd0;
    build_program();
    run_model();
    repeat (2) @(posedge clock);
    rst_n <= 1'b1;
    // Started flag sets on the next edge and the first retire follows
    @(posedge clock);
    #1;
    assert (pc == `RV_INITIAL_PC)
    else begin
      $display("error @%0t: pc %h before first retire", $time, pc);
      errors++;
    end
    run_section("alu", end_label[0]);
    run_section("upper_and_jumps", end_label[1]);
    run_section("branches", end_label[2]);
    run_section("x0_write", end_label[3]);
    $display("tests passed: %0d, failed: %0d, errors: %0d", tests_passed, tests_failed,
             errors);
    if (errors == 0 && tests_failed == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

/* verification/rvsimple_checker.sv */
/*
 * Protocol checks on the core's pc and memory strobes.
 * Bound into every rvsimple_core instance.
 */

`timescale 1ns/1ps

`include "rv_consts.svh"

module rvsimple_checker (
  input logic                clock,
  input logic                rst_n,
  input logic [`RV_XLEN-1:0] pc,
  input logic                write_enable,
  input logic                read_enable
);

  // Pc is held at the reset vector
  reset_pc: assert property (@(posedge clock) !rst_n |-> pc == `RV_INITIAL_PC)
    else $error("pc left the reset vector during reset");

  reset_strobes: assert property (@(posedge clock) !rst_n |-> !write_enable && !read_enable)
    else $error("memory strobe during reset");

  one_strobe: assert property (@(posedge clock) disable iff (!rst_n)
    !(write_enable && read_enable))
    else $error("read and write strobes high together");

  pc_aligned: assert property (@(posedge clock) pc[1:0] == 2'b00)
    else $error("pc is not word aligned");

endmodule

bind rvsimple_core rvsimple_checker chk_i (
  .clock        (clock),
  .rst_n        (rst_n),
  .pc           (pc),
  .write_enable (data_mem_write_enable),
  .read_enable  (data_mem_read_enable)
);

/* src/rvsimple_core.sv */
/*
 * Top level of the single-cycle RV32I core. Instruction and data
 * memories are external and accessed with plain single-cycle strobes.
 */

`timescale 1ns/1ps

`include "rv_consts.svh"

module rvsimple_core (
  input  logic                clock,
  input  logic                rst_n,
  output logic [`RV_XLEN-1:0] pc,
  input  rv_isa_pkg::inst_t   inst,
  output logic [`RV_XLEN-1:0] data_mem_address,
  output logic [`RV_XLEN-1:0] data_mem_write_data,
  output logic                data_mem_write_enable,
  output logic                data_mem_read_enable,
  input  logic [`RV_XLEN-1:0] data_mem_read_data
);

  import rv_ctrl_pkg::*;

  ctrl_t      ctrl;
  logic [6:0] inst_opcode;
  logic [2:0] inst_funct3;
  logic [6:0] inst_funct7;
  logic       alu_result_equal_zero;

  singlecycle_control control (
    .clock                 (clock),
    .rst_n                 (rst_n),
    .inst_opcode           (inst_opcode),
    .inst_funct3           (inst_funct3),
    .inst_funct7           (inst_funct7),
    .alu_result_equal_zero (alu_result_equal_zero),
    .ctrl                  (ctrl)
  );

  singlecycle_datapath datapath (
    .clock                 (clock),
    .rst_n                 (rst_n),
    .inst                  (inst),
    .ctrl                  (ctrl),
    .data_mem_read_data    (data_mem_read_data),
    .pc                    (pc),
    .data_mem_address      (data_mem_address),
    .data_mem_write_data   (data_mem_write_data),
    .inst_opcode           (inst_opcode),
    .inst_funct3           (inst_funct3),
    .inst_funct7           (inst_funct7),
    .alu_result_equal_zero (alu_result_equal_zero)
  );

  assign data_mem_write_enable = ctrl.mem_write;
  assign data_mem_read_enable  = ctrl.mem_read;

endmodule

/* src/singlecycle_control.sv */
/*
 * Control unit: decodes opcode, funct3 and funct7 into the control word
 * and resolves branches from the ALU zero flag.
 */

`timescale 1ns/1ps

module singlecycle_control (
  input  logic               clock,
  input  logic               rst_n,
  input  logic [6:0]         inst_opcode,
  input  logic [2:0]         inst_funct3,
  input  logic [6:0]         inst_funct7,
  input  logic               alu_result_equal_zero,
  output rv_ctrl_pkg::ctrl_t ctrl
);

  import rv_isa_pkg::*;
  import rv_ctrl_pkg::*;

  logic started;

  // ALU op from funct3; alt is funct7 bit 5
  function automatic alu_fn_e arith_fn(input logic [2:0] funct3, input logic alt,
                                       input logic is_reg);
    case (funct3)
      3'b000:  return (is_reg && alt) ? SUB : ADD;
      3'b001:  return SLL;
      3'b010:  return SLT;
      3'b011:  return SLTU;
      3'b100:  return XOR;
      3'b101:  return alt ? SRA : SRL;
      3'b110:  return OR;
      default: return AND;
    endcase
  endfunction

  function automatic alu_fn_e branch_fn(input logic [2:0] funct3);
    case (funct3)
      BNE:     return SNE;
      BLT:     return SLT;
      BGE:     return SGE;
      BLTU:    return SLTU;
      BGEU:    return SGEU;
      default: return SEQ;
    endcase
  endfunction

  // Nothing commits in the first cycle after reset
  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      started <= 1'b0;
    end else begin
      started <= 1'b1;
    end
  end

  always_comb begin
    // Unknown opcodes fall through as a no-op that still advances the pc
    ctrl = '{pc_write_enable: 1'b1, regfile_write_enable: 1'b0, alu_fn: ADD,
             opa_sel: OPA_RS1, opb_sel: OPB_RS2, wb_sel: WB_ALU,
             next_pc: NPC_PC4, mem_read: 1'b0, mem_write: 1'b0};
    case (inst_opcode)
      OP_LUI: begin
        ctrl.regfile_write_enable = 1'b1;
        ctrl.wb_sel = WB_IMM;
      end
      OP_AUIPC: begin
        ctrl.regfile_write_enable = 1'b1;
        ctrl.opa_sel = OPA_PC;
        ctrl.opb_sel = OPB_IMM;
      end
      OP_JAL: begin
        ctrl.regfile_write_enable = 1'b1;
        ctrl.wb_sel = WB_PC4;
        ctrl.next_pc = NPC_PC_IMM;
      end
      OP_JALR: begin
        ctrl.regfile_write_enable = 1'b1;
        ctrl.opb_sel = OPB_IMM;
        ctrl.wb_sel = WB_PC4;
        ctrl.next_pc = NPC_ALU;
      end
      OP_BRANCH: begin
        ctrl.alu_fn = branch_fn(inst_funct3);
        ctrl.next_pc = alu_result_equal_zero ? NPC_PC4 : NPC_PC_IMM;
      end
      OP_LOAD: begin
        ctrl.regfile_write_enable = 1'b1;
        ctrl.opb_sel = OPB_IMM;
        ctrl.wb_sel = WB_MEM;
        ctrl.mem_read = 1'b1;
      end
      OP_STORE: begin
        ctrl.opb_sel = OPB_IMM;
        ctrl.mem_write = 1'b1;
      end
      OP_IMM: begin
        ctrl.regfile_write_enable = 1'b1;
        ctrl.opb_sel = OPB_IMM;
        ctrl.alu_fn = arith_fn(inst_funct3, inst_funct7[5], 1'b0);
      end
      OP_REG: begin
        ctrl.regfile_write_enable = 1'b1;
        ctrl.alu_fn = arith_fn(inst_funct3, inst_funct7[5], 1'b1);
      end
      default: begin
      end
    endcase
    ctrl.pc_write_enable      = ctrl.pc_write_enable & started;
    ctrl.regfile_write_enable = ctrl.regfile_write_enable & started;
    ctrl.mem_read             = ctrl.mem_read & started;
    ctrl.mem_write            = ctrl.mem_write & started;
  end

endmodule

/* src/singlecycle_datapath.sv */
/*
 * Single-cycle datapath: pc register, register file, ALU, operand and
 * writeback muxes and next-pc selection, steered by the control word.
 */

`timescale 1ns/1ps

`include "rv_consts.svh"

module singlecycle_datapath (
  input  logic                clock,
  input  logic                rst_n,
  input  rv_isa_pkg::inst_t   inst,
  input  rv_ctrl_pkg::ctrl_t  ctrl,
  input  logic [`RV_XLEN-1:0] data_mem_read_data,
  output logic [`RV_XLEN-1:0] pc,
  output logic [`RV_XLEN-1:0] data_mem_address,
  output logic [`RV_XLEN-1:0] data_mem_write_data,
  output logic [6:0]          inst_opcode,
  output logic [2:0]          inst_funct3,
  output logic [6:0]          inst_funct7,
  output logic                alu_result_equal_zero
);

  import rv_ctrl_pkg::*;

  logic [`RV_XLEN-1:0] immediate;
  logic [`RV_XLEN-1:0] rs1_data;
  logic [`RV_XLEN-1:0] rs2_data;
  logic [`RV_XLEN-1:0] rd_data;
  logic [`RV_XLEN-1:0] operand_a;
  logic [`RV_XLEN-1:0] operand_b;
  logic [`RV_XLEN-1:0] alu_result;
  logic [`RV_XLEN-1:0] pc_plus_4;
  logic [`RV_XLEN-1:0] pc_plus_imm;
  logic [`RV_XLEN-1:0] next_pc;

  // Fields for the control unit
  assign inst_opcode = inst.r_type.opcode;
  assign inst_funct3 = inst.r_type.funct3;
  assign inst_funct7 = inst.r_type.funct7;

  // ----------------------------------------------------------------------
  // Program counter
  // ----------------------------------------------------------------------

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      pc <= `RV_INITIAL_PC;
    end else if (ctrl.pc_write_enable) begin
      pc <= next_pc;
    end
  end

  assign pc_plus_4   = pc + `RV_XLEN'd4;
  assign pc_plus_imm = pc + immediate;

  always_comb begin
    case (ctrl.next_pc)
      NPC_PC_IMM: next_pc = pc_plus_imm;
      NPC_ALU:    next_pc = {alu_result[`RV_XLEN-1:1], 1'b0};
      default:    next_pc = pc_plus_4;
    endcase
  end

  // ----------------------------------------------------------------------
  // Execute and writeback
  // ----------------------------------------------------------------------

  immediate_generator igen (
    .inst      (inst),
    .immediate (immediate)
  );

  regfile regs (
    .clock        (clock),
    .write_enable (ctrl.regfile_write_enable),
    .rd_address   (inst.r_type.rd),
    .rs1_address  (inst.r_type.rs1),
    .rs2_address  (inst.r_type.rs2),
    .rd_data      (rd_data),
    .rs1_data     (rs1_data),
    .rs2_data     (rs2_data)
  );

  assign operand_a = (ctrl.opa_sel == OPA_PC) ? pc : rs1_data;
  assign operand_b = (ctrl.opb_sel == OPB_IMM) ? immediate : rs2_data;

  alu alu_core (
    .alu_function      (ctrl.alu_fn),
    .operand_a         (operand_a),
    .operand_b         (operand_b),
    .result            (alu_result),
    .result_equal_zero (alu_result_equal_zero)
  );

  always_comb begin
    case (ctrl.wb_sel)
      WB_MEM:  rd_data = data_mem_read_data;
      WB_PC4:  rd_data = pc_plus_4;
      WB_IMM:  rd_data = immediate;
      default: rd_data = alu_result;
    endcase
  end

  // Effective address comes from the ALU, store data is always rs2
  assign data_mem_address    = alu_result;
  assign data_mem_write_data = rs2_data;

endmodule

/* src/immediate_generator.sv */
/*
 * Builds the sign-extended immediate of the current instruction,
 * picking the format from the opcode. R-type yields zero.
 */

`timescale 1ns/1ps

`include "rv_consts.svh"

module immediate_generator (
  input  rv_isa_pkg::inst_t   inst,
  output logic [`RV_XLEN-1:0] immediate
);

  import rv_isa_pkg::*;

  always_comb begin
    case (inst.r_type.opcode)
      OP_IMM, OP_LOAD, OP_JALR: begin
        immediate = {{20{inst.i_type.imm_11_0[11]}}, inst.i_type.imm_11_0};
      end
      OP_STORE: begin
        immediate = {{20{inst.s_type.imm_11_5[6]}},
                     inst.s_type.imm_11_5, inst.s_type.imm_4_0};
      end
      // Branch and jump offsets are multiples of two
      OP_BRANCH: begin
        immediate = {{19{inst.b_type.imm_12}}, inst.b_type.imm_12,
                     inst.b_type.imm_11, inst.b_type.imm_10_5,
                     inst.b_type.imm_4_1, 1'b0};
      end
      OP_JAL: begin
        immediate = {{11{inst.j_type.imm_20}}, inst.j_type.imm_20,
                     inst.j_type.imm_19_12, inst.j_type.imm_11,
                     inst.j_type.imm_10_1, 1'b0};
      end
      OP_LUI, OP_AUIPC: begin
        immediate = {inst.u_type.imm_31_12, 12'h000};
      end
      default: begin
        immediate = '0;
      end
    endcase
  end

endmodule

/* src/regfile.sv */
/*
 * Integer register file with x0 tied to zero. Two combinational read
 * ports and one write port that updates on the rising clock edge.
 */

`timescale 1ns/1ps

`include "rv_consts.svh"

module regfile (
  input  logic                      clock,
  input  logic                      write_enable,
  input  logic [`RV_REG_ADDR_W-1:0] rd_address,
  input  logic [`RV_REG_ADDR_W-1:0] rs1_address,
  input  logic [`RV_REG_ADDR_W-1:0] rs2_address,
  input  logic [`RV_XLEN-1:0]       rd_data,
  output logic [`RV_XLEN-1:0]       rs1_data,
  output logic [`RV_XLEN-1:0]       rs2_data
);

  // Only x1..x31 have storage
  logic [`RV_XLEN-1:0] regs [1:`RV_NUM_REGS-1];

  always_ff @(posedge clock) begin
    if (write_enable && rd_address != '0) begin
      regs[rd_address] <= rd_data;
    end
  end

  assign rs1_data = (rs1_address == '0) ? '0 : regs[rs1_address];
  assign rs2_data = (rs2_address == '0) ? '0 : regs[rs2_address];

endmodule

/* src/alu.sv */
/*
 * Integer ALU for the single-cycle core. Comparison functions return
 * 0 or 1 so branches can be resolved from the zero flag.
 */

`timescale 1ns/1ps

`include "rv_consts.svh"

module alu (
  input  rv_ctrl_pkg::alu_fn_e alu_function,
  input  logic [`RV_XLEN-1:0]  operand_a,
  input  logic [`RV_XLEN-1:0]  operand_b,
  output logic [`RV_XLEN-1:0]  result,
  output logic                 result_equal_zero
);

  import rv_ctrl_pkg::*;

  logic [4:0] shamt;
  logic       lt_signed;
  logic       lt_unsigned;

  assign shamt       = operand_b[4:0];
  assign lt_signed   = $signed(operand_a) < $signed(operand_b);
  assign lt_unsigned = operand_a < operand_b;

  always_comb begin
    case (alu_function)
      ADD:     result = operand_a + operand_b;
      SUB:     result = operand_a - operand_b;
      SLL:     result = operand_a << shamt;
      SRL:     result = operand_a >> shamt;
      SRA:     result = $signed(operand_a) >>> shamt;
      XOR:     result = operand_a ^ operand_b;
      OR:      result = operand_a | operand_b;
      AND:     result = operand_a & operand_b;
      // Comparisons, zero-extended single bit
      SLT:     result = {{(`RV_XLEN-1){1'b0}}, lt_signed};
      SLTU:    result = {{(`RV_XLEN-1){1'b0}}, lt_unsigned};
      SEQ:     result = {{(`RV_XLEN-1){1'b0}}, operand_a == operand_b};
      SNE:     result = {{(`RV_XLEN-1){1'b0}}, operand_a != operand_b};
      SGE:     result = {{(`RV_XLEN-1){1'b0}}, !lt_signed};
      SGEU:    result = {{(`RV_XLEN-1){1'b0}}, !lt_unsigned};
      default: result = '0;
    endcase
  end

  assign result_equal_zero = (result == '0);

endmodule

/* src/rv_ctrl_pkg.sv */
/*
 * Control types passed from the control unit to the datapath:
 * ALU functions, mux selects and the bundled control word.
 */

package rv_ctrl_pkg;

  typedef enum logic [4:0] {
    ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND,
    SEQ, SNE, SGE, SGEU
  } alu_fn_e;

  typedef enum logic {
    OPA_RS1,
    OPA_PC
  } opa_sel_e;

  typedef enum logic {
    OPB_RS2,
    OPB_IMM
  } opb_sel_e;

  typedef enum logic [1:0] {
    WB_ALU,
    WB_MEM,
    WB_PC4,
    WB_IMM
  } wb_sel_e;

  // Jump register target has bit 0 cleared
  typedef enum logic [1:0] {
    NPC_PC4,
    NPC_PC_IMM,
    NPC_ALU
  } next_pc_e;

  typedef struct packed {
    logic     pc_write_enable;
    logic     regfile_write_enable;
    alu_fn_e  alu_fn;
    opa_sel_e opa_sel;
    opb_sel_e opb_sel;
    wb_sel_e  wb_sel;
    next_pc_e next_pc;
    logic     mem_read;
    logic     mem_write;
  } ctrl_t;

endpackage

/* src/rv_isa_pkg.sv */
/*
 * RV32I instruction encodings: the per-format views of one instruction
 * word, the supported major opcodes and the branch funct3 codes.
 */

package rv_isa_pkg;

  typedef enum logic [6:0] {
    OP_LUI    = 7'b0110111,
    OP_AUIPC  = 7'b0010111,
    OP_JAL    = 7'b1101111,
    OP_JALR   = 7'b1100111,
    OP_BRANCH = 7'b1100011,
    OP_LOAD   = 7'b0000011,
    OP_STORE  = 7'b0100011,
    OP_IMM    = 7'b0010011,
    OP_REG    = 7'b0110011
  } opcode_e;

  typedef enum logic [2:0] {
    BEQ  = 3'b000,
    BNE  = 3'b001,
    BLT  = 3'b100,
    BGE  = 3'b101,
    BLTU = 3'b110,
    BGEU = 3'b111
  } branch_e;

  // Register-register format
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_type_t;

  typedef struct packed {
    logic [11:0] imm_11_0;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_type_t;

  typedef struct packed {
    logic [6:0] imm_11_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_4_0;
    logic [6:0] opcode;
  } s_type_t;

  // Branch offset bits are scattered, bit 0 is implied zero
  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    logic [6:0] opcode;
  } b_type_t;

  typedef struct packed {
    logic [19:0] imm_31_12;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } u_type_t;

  typedef struct packed {
    logic       imm_20;
    logic [9:0] imm_10_1;
    logic       imm_11;
    logic [7:0] imm_19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } j_type_t;

  typedef union packed {
    r_type_t r_type;
    i_type_t i_type;
    s_type_t s_type;
    b_type_t b_type;
    u_type_t u_type;
    j_type_t j_type;
  } inst_t;

endpackage

/* src/rv_consts.svh */
/*
 * Core-wide sizes and the reset pc, shared by the RTL and the testbench.
 * Include wherever one of these values is needed.
 */

`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

// ----------------------------------------------------------------------
// Data path
// ----------------------------------------------------------------------

`define RV_XLEN 32

// ----------------------------------------------------------------------
// Register file
// ----------------------------------------------------------------------

`define RV_REG_ADDR_W 5
`define RV_NUM_REGS 32

// Pc held during reset and fetched first after it
`define RV_INITIAL_PC 32'h0000_0000

`endif
